// File: Makefile
SRCS = $(wildcard hw/*.sv test/*.sv)

all: run

obj_dir/Vdcache_tb: dcache.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f dcache.f --top-module dcache_tb -o Vdcache_tb

run: obj_dir/Vdcache_tb
	./obj_dir/Vdcache_tb | tee sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: dcache.f
hw/dcache_pkg.sv
hw/dcache_ctrl.sv
hw/dcache_tag_store.sv
hw/dcache_line_store.sv
hw/dcache_mem_port.sv
hw/dcache_top.sv
test/dcache_mem_model.sv
test/dcache_tb.sv

// File: hw/dcache_ctrl.sv
// Cache FSM: captures a request, checks the tags, then sequences write-back, fill and flush
`timescale 1ns/1ps

module dcache_ctrl #(
	parameter int index_w = 4
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     enable,
	input  dcache_pkg::dc_req_t      req,
	input  logic [1:0]               hit,
	input  logic                     victim_way,
	input  logic                     victim_dirty,
	input  logic                     mem_done,
	output dcache_pkg::dc_req_t      cur_req,
	output logic [index_w-1:0]       set_index,
	output logic [1:0]               meta_we,
	output dcache_pkg::dc_meta_t     meta_new,
	output logic [1:0]               line_we,
	output logic                     line_fill,
	output logic                     word_we,
	output logic                     mem_load,
	output logic                     mem_write,
	output logic                     done
);

	localparam int tag_w = dcache_pkg::tag_w(index_w);

	dcache_pkg::ctrl_state_e state_q;
	dcache_pkg::ctrl_state_e state_d;
	logic done_d;
	logic [1:0] way_onehot;

	assign set_index = cur_req.addr[dcache_pkg::offset_w +: index_w];
	assign way_onehot = victim_way ? 2'b10 : 2'b01; // Victim is the hit way on a hit

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= dcache_pkg::st_idle;
			done <= 1'b0;
			cur_req <= '0;
		end else begin
			state_q <= state_d;
			done <= done_d;
			if (state_q == dcache_pkg::st_idle && enable)
				cur_req <= req;
		end
	end

	////////////////////////////////////////////////////////////
	// Next state and datapath enables
	////////////////////////////////////////////////////////////

	always_comb begin
		state_d = state_q;
		done_d = 1'b0;
		meta_we = '0;
		meta_new = '0;
		meta_new.tag[tag_w-1:0] = cur_req.addr[dcache_pkg::addr_w-1 -: tag_w];
		meta_new.valid = 1'b1;
		meta_new.dirty = cur_req.write;
		meta_new.recent = 1'b1; // Tag store clears the other way
		line_we = '0;
		line_fill = 1'b0;
		word_we = 1'b0;
		mem_load = 1'b0;
		mem_write = 1'b0;

		case (state_q)
			dcache_pkg::st_idle: begin
				if (enable)
					state_d = dcache_pkg::st_lookup;
			end
			dcache_pkg::st_lookup: begin
				state_d = dcache_pkg::st_check; // Arrays are read on this edge
			end
			dcache_pkg::st_check: begin
				if (cur_req.flush) begin
					if (|hit) begin
						mem_load = 1'b1;
						mem_write = 1'b1;
						state_d = dcache_pkg::st_flush_wb;
					end else begin
						done_d = 1'b1;
						state_d = dcache_pkg::st_idle;
					end
				end else if (|hit) begin
					meta_we = hit;
					meta_new.dirty = cur_req.write | victim_dirty;
					line_we = cur_req.write ? hit : 2'b00;
					word_we = cur_req.write;
					done_d = 1'b1;
					state_d = dcache_pkg::st_idle;
				end else begin
					// Miss, a dirty victim goes out first
					mem_load = 1'b1;
					mem_write = victim_dirty;
					state_d = victim_dirty ? dcache_pkg::st_wb : dcache_pkg::st_fill;
				end
			end
			dcache_pkg::st_wb: begin
				if (mem_done) begin
					mem_load = 1'b1;
					state_d = dcache_pkg::st_fill;
				end
			end
			dcache_pkg::st_fill: begin
				if (mem_done) begin
					meta_we = way_onehot;
					line_we = way_onehot;
					line_fill = 1'b1;
					word_we = cur_req.write; // Write miss merges on top of the fill
					done_d = 1'b1;
					state_d = dcache_pkg::st_idle;
				end
			end
			dcache_pkg::st_flush_wb: begin
				if (mem_done) begin
					meta_we = way_onehot;
					meta_new.valid = 1'b0;
					meta_new.dirty = 1'b0;
					meta_new.recent = 1'b0;
					done_d = 1'b1;
					state_d = dcache_pkg::st_idle;
				end
			end
			default: state_d = dcache_pkg::st_idle;
		endcase
	end

	// Processor must issue word-aligned addresses
	a_req_aligned: assert property (@(posedge clk) disable iff (rst)
		(state_q == dcache_pkg::st_idle && enable) |-> (req.addr[2:0] == 3'b000));

endmodule

// File: hw/dcache_line_store.sv
// Two data ways of full lines with fill, word merge and word select
`timescale 1ns/1ps

module dcache_line_store #(
	parameter int index_w = 4
) (
	input  logic                                 clk,
	input  logic [index_w-1:0]                   set_index,
	input  logic [dcache_pkg::word_sel_w-1:0]    word_sel,
	input  logic [1:0]                           line_we,
	input  logic                                 line_fill,
	input  logic                                 word_we,
	input  dcache_pkg::dc_line_t                 fill_line,
	input  logic [dcache_pkg::word_w-1:0]        write_word,
	input  logic                                 way_sel,
	output dcache_pkg::dc_line_t                 line_out,
	output logic [dcache_pkg::word_w-1:0]        word_out
);

	localparam int sets = 2 ** index_w;

	dcache_pkg::dc_line_t way_mem [2][sets];
	dcache_pkg::dc_line_t new_line [2];
	dcache_pkg::dc_line_t rd_line [2];

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			new_line[w] = line_fill ? fill_line : way_mem[w][set_index];
			if (word_we)
				new_line[w].words[word_sel] = write_word;
		end
	end

	always_ff @(posedge clk) begin
		for (int w = 0; w < 2; w++) begin
			if (line_we[w]) begin
				way_mem[w][set_index] <= new_line[w];
				rd_line[w] <= new_line[w]; // Written line shows up on the next cycle
			end else begin
				rd_line[w] <= way_mem[w][set_index];
			end
		end
	end

	assign line_out = rd_line[way_sel];
	assign word_out = line_out.words[word_sel];

endmodule

// File: hw/dcache_mem_port.sv
// Line-side port: holds one transfer and its request strobe until acknowledged
`timescale 1ns/1ps

module dcache_mem_port (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               mem_load,
	input  dcache_pkg::mem_req_t               mem_req,
	output logic                               drequest,
	input  logic                               dreqack,
	output logic [dcache_pkg::addr_w-1:0]      daddr,
	output logic                               dwrenable,
	output dcache_pkg::dc_line_t               dwdata,
	input  dcache_pkg::dc_line_t               drdata,
	input  logic                               ddone,
	output logic                               mem_done,
	output dcache_pkg::dc_line_t               fill_line
);

	dcache_pkg::mem_req_t req_q;
	logic busy;

	always_ff @(posedge clk) begin
		if (rst) begin
			drequest <= 1'b0;
			busy <= 1'b0;
		end else if (mem_load) begin
			drequest <= 1'b1;
			busy <= 1'b1;
		end else begin
			if (dreqack)
				drequest <= 1'b0;
			if (ddone)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_load)
			req_q <= mem_req;
	end

	assign daddr = {req_q.line_addr, {dcache_pkg::offset_w{1'b0}}};
	assign dwrenable = req_q.write;
	assign dwdata = req_q.data;

	assign mem_done = ddone && busy;
	assign fill_line = drdata;

	// A new transfer only starts once the previous one has ended
	a_no_overlap: assert property (@(posedge clk) disable iff (rst)
		mem_load |-> (!busy || ddone));

endmodule

// File: hw/dcache_pkg.sv
// Shared geometry, request, metadata, line and state types for the data cache blocks
package dcache_pkg;

	////////////////////////////////////////////////////////////
	// Geometry
	////////////////////////////////////////////////////////////

	localparam int addr_w = 32;
	localparam int word_w = 64;
	localparam int line_words = 8;
	localparam int offset_w = 6; // 64-byte line
	localparam int word_sel_w = $clog2(line_words);

	// Widest tag, reached with a single index bit
	localparam int meta_tag_w = addr_w - offset_w - 1;

	function automatic int tag_w(input int index_w);
		return addr_w - index_w - offset_w;
	endfunction

	////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic [word_w-1:0] wdata;
		logic              write;
		logic              flush;
	} dc_req_t;

	// Tag sits in the low bits, upper bits stay zero
	typedef struct packed {
		logic [meta_tag_w-1:0] tag;
		logic                  valid;
		logic                  dirty;
		logic                  recent;
	} dc_meta_t;

	typedef union packed {
		logic [line_words*word_w-1:0]         flat;
		logic [line_words-1:0][word_w-1:0]    words;
	} dc_line_t;

	typedef struct packed {
		logic [addr_w-offset_w-1:0] line_addr;
		logic                       write;
		dc_line_t                   data;
	} mem_req_t;

	typedef enum logic [2:0] {
		st_idle,
		st_lookup,
		st_check,
		st_wb,
		st_fill,
		st_flush_wb
	} ctrl_state_e;

endpackage

// File: hw/dcache_tag_store.sv
// Per-way tag, valid, dirty and recency storage with hit detection and victim choice
`timescale 1ns/1ps

module dcache_tag_store #(
	parameter int index_w = 4
) (
	input  logic                                     clk,
	input  logic                                     rst,
	input  logic [index_w-1:0]                       set_index,
	input  logic [dcache_pkg::tag_w(index_w)-1:0]    tag,
	input  logic [1:0]                               meta_we,
	input  dcache_pkg::dc_meta_t                     meta_new,
	output logic [1:0]                               hit,
	output logic                                     victim_way,
	output logic                                     victim_dirty,
	output logic [dcache_pkg::tag_w(index_w)-1:0]    victim_tag
);

	localparam int tag_w = dcache_pkg::tag_w(index_w);
	localparam int sets = 2 ** index_w;

	logic [tag_w-1:0] tag_mem [2][sets];
	logic [sets-1:0] valid_q [2];
	logic [sets-1:0] dirty_q [2];
	logic [sets-1:0] recent_q [2];
	dcache_pkg::dc_meta_t cur_meta [2];
	dcache_pkg::dc_meta_t nxt_meta [2];
	dcache_pkg::dc_meta_t rd_meta [2];
	logic [1:0] meta_wr;

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			cur_meta[w] = '0;
			cur_meta[w].tag[tag_w-1:0] = tag_mem[w][set_index];
			cur_meta[w].valid = valid_q[w][set_index];
			cur_meta[w].dirty = dirty_q[w][set_index];
			cur_meta[w].recent = recent_q[w][set_index];
		end
		for (int w = 0; w < 2; w++) begin
			nxt_meta[w] = cur_meta[w];
			meta_wr[w] = meta_we[w];
			if (meta_we[w]) begin
				nxt_meta[w] = meta_new;
			end else if (meta_we[1-w] && meta_new.recent && cur_meta[w].valid) begin
				nxt_meta[w].recent = 1'b0; // Other valid way loses recency
				meta_wr[w] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < 2; w++) begin
				valid_q[w] <= '0;
				dirty_q[w] <= '0;
				recent_q[w] <= '0;
			end
		end else begin
			for (int w = 0; w < 2; w++) begin
				if (meta_wr[w]) begin
					valid_q[w][set_index] <= nxt_meta[w].valid;
					dirty_q[w][set_index] <= nxt_meta[w].dirty;
					recent_q[w][set_index] <= nxt_meta[w].recent;
				end
			end
		end
	end

	// Read register follows the write so the done cycle sees fresh state
	always_ff @(posedge clk) begin
		for (int w = 0; w < 2; w++) begin
			if (meta_wr[w])
				tag_mem[w][set_index] <= nxt_meta[w].tag[tag_w-1:0];
			rd_meta[w] <= nxt_meta[w];
		end
	end

	always_comb begin
		for (int w = 0; w < 2; w++)
			hit[w] = rd_meta[w].valid && (rd_meta[w].tag[tag_w-1:0] == tag);

		if (hit[0])
			victim_way = 1'b0;
		else if (hit[1])
			victim_way = 1'b1;
		else if (!rd_meta[0].valid)
			victim_way = 1'b0;
		else if (!rd_meta[1].valid)
			victim_way = 1'b1;
		else
			victim_way = !rd_meta[1].recent; // Way 1 unless it was used last

		victim_dirty = rd_meta[victim_way].valid && rd_meta[victim_way].dirty;
		victim_tag = rd_meta[victim_way].tag[tag_w-1:0];
	end

	// Allocation never leaves the same tag in both ways
	a_hit_onehot: assert property (@(posedge clk) disable iff (rst) !(&hit));

endmodule

// File: hw/dcache_top.sv
// Data cache top: wires the FSM, tag store, line store and memory port together
`timescale 1ns/1ps

module dcache_top #(
	parameter int index_w = 4
) (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               enable,
	input  logic [dcache_pkg::addr_w-1:0]      addr,
	input  logic [dcache_pkg::word_w-1:0]      wdata,
	input  logic                               wen,
	input  logic                               clflush,
	output logic [dcache_pkg::word_w-1:0]      rdata,
	output logic                               done,
	output logic                               drequest,
	input  logic                               dreqack,
	output logic [dcache_pkg::addr_w-1:0]      daddr,
	output logic                               dwrenable,
	output dcache_pkg::dc_line_t               dwdata,
	input  dcache_pkg::dc_line_t               drdata,
	input  logic                               ddone
);

	localparam int tag_w = dcache_pkg::tag_w(index_w);

	dcache_pkg::dc_req_t req;
	dcache_pkg::dc_req_t cur_req;
	dcache_pkg::dc_meta_t meta_new;
	dcache_pkg::dc_line_t fill_line;
	dcache_pkg::dc_line_t line_out;
	dcache_pkg::mem_req_t mem_req;
	logic [index_w-1:0] set_index;
	logic [tag_w-1:0] victim_tag;
	logic [1:0] hit;
	logic [1:0] meta_we;
	logic [1:0] line_we;
	logic victim_way;
	logic victim_dirty;
	logic line_fill;
	logic word_we;
	logic mem_load;
	logic mem_write;
	logic mem_done;

	assign req = '{addr: addr, wdata: wdata, write: wen, flush: clflush};

	// Write-backs go to the victim's line, fills to the requested one
	assign mem_req = '{
		line_addr: mem_write ? {victim_tag, set_index}
			: cur_req.addr[dcache_pkg::addr_w-1:dcache_pkg::offset_w],
		write: mem_write,
		data: line_out
	};

	dcache_ctrl #(.index_w(index_w)) ctrl_i (
		.clk(clk), .rst(rst), .enable(enable), .req(req),
		.hit(hit), .victim_way(victim_way), .victim_dirty(victim_dirty),
		.mem_done(mem_done), .cur_req(cur_req), .set_index(set_index),
		.meta_we(meta_we), .meta_new(meta_new), .line_we(line_we),
		.line_fill(line_fill), .word_we(word_we), .mem_load(mem_load),
		.mem_write(mem_write), .done(done)
	);

	dcache_tag_store #(.index_w(index_w)) tag_i (
		.clk(clk), .rst(rst), .set_index(set_index),
		.tag(cur_req.addr[dcache_pkg::addr_w-1 -: tag_w]),
		.meta_we(meta_we), .meta_new(meta_new), .hit(hit),
		.victim_way(victim_way), .victim_dirty(victim_dirty), .victim_tag(victim_tag)
	);

	dcache_line_store #(.index_w(index_w)) line_i (
		.clk(clk), .set_index(set_index),
		.word_sel(cur_req.addr[dcache_pkg::offset_w-1 -: dcache_pkg::word_sel_w]),
		.line_we(line_we), .line_fill(line_fill), .word_we(word_we),
		.fill_line(fill_line), .write_word(cur_req.wdata), .way_sel(victim_way),
		.line_out(line_out), .word_out(rdata)
	);

	dcache_mem_port mem_i (
		.clk(clk), .rst(rst), .mem_load(mem_load), .mem_req(mem_req),
		.drequest(drequest), .dreqack(dreqack), .daddr(daddr),
		.dwrenable(dwrenable), .dwdata(dwdata), .drdata(drdata), .ddone(ddone),
		.mem_done(mem_done), .fill_line(fill_line)
	);

endmodule

// File: test/dcache_mem_model.sv
// Testbench line memory that answers cache line transfers after random acknowledge and done delays
`timescale 1ns/1ps

module dcache_mem_model #(
	parameter int seed_init = 1
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              drequest,
	output logic                              dreqack,
	input  logic [dcache_pkg::addr_w-1:0]     daddr,
	input  logic                              dwrenable,
	input  dcache_pkg::dc_line_t              dwdata,
	output dcache_pkg::dc_line_t              drdata,
	output logic                              ddone
);

	dcache_pkg::dc_line_t lines [logic [25:0]];
	dcache_pkg::dc_line_t wr_line;
	logic [25:0] line_addr;
	logic write;
	int seed = seed_init;
	int phase;
	int delay;

	// Untouched lines read back a pattern of their own word addresses
	function automatic dcache_pkg::dc_line_t initial_line(input logic [25:0] la);
		dcache_pkg::dc_line_t l;
		logic [31:0] a;
		for (int w = 0; w < 8; w++) begin
			a = {la, w[2:0], 3'b000};
			l.words[w] = {~a, a};
		end
		return l;
	endfunction

	initial begin
		dreqack = 1'b0;
		ddone = 1'b0;
		drdata = '0;
	end

	always @(posedge clk) begin
		if (rst) begin
			phase <= 0;
			dreqack <= 1'b0;
			ddone <= 1'b0;
		end else begin
			dreqack <= 1'b0;
			ddone <= 1'b0;
			case (phase)
				0: if (drequest) begin
					line_addr <= daddr[31:6];
					write <= dwrenable;
					wr_line <= dwdata;
					delay <= {$random(seed)} % 4;
					phase <= 1;
				end
				1: if (delay == 0) begin
					dreqack <= 1'b1; // Held for one cycle only
					delay <= {$random(seed)} % 5;
					phase <= 2;
				end else begin
					delay <= delay - 1;
				end
				default: if (delay == 0) begin
					if (write)
						lines[line_addr] = wr_line;
					else if (lines.exists(line_addr))
						drdata <= lines[line_addr];
					else
						drdata <= initial_line(line_addr);
					ddone <= 1'b1;
					phase <= 0;
				end else begin
					delay <= delay - 1;
				end
			endcase
		end
	end

endmodule

// File: test/dcache_tb.sv
// Testbench top: random reads, writes and flushes on the cache, checked against a shadow model
`timescale 1ns/1ps

module dcache_tb;

	localparam int index_w = 2;
	localparam int tag_w = dcache_pkg::tag_w(index_w);
	localparam int num_ops = 400;
	localparam int done_limit = 200;

	logic clk;
	logic rst;
	logic enable;
	logic [31:0] addr;
	logic [63:0] wdata;
	logic wen;
	logic clflush;
	logic [63:0] rdata;
	logic done;
	logic drequest;
	logic dreqack;
	logic [31:0] daddr;
	logic dwrenable;
	dcache_pkg::dc_line_t dwdata;
	dcache_pkg::dc_line_t drdata;
	logic ddone;

	int seed = 32'h53fe_5be3;
	int checks = 0;
	int errors = 0;
	int timeouts = 0;

	logic [tag_w-1:0] sh_tag [2][4]; // Shadow metadata indexed by way then set
	logic sh_valid [2][4];
	logic sh_dirty [2][4];
	logic sh_recent [2][4];
	logic [63:0] gold [logic [28:0]];
	dcache_pkg::mem_req_t seen [$];
	dcache_pkg::mem_req_t mon_req;

	dcache_top #(.index_w(index_w)) dut_i (
		.clk(clk), .rst(rst), .enable(enable), .addr(addr), .wdata(wdata),
		.wen(wen), .clflush(clflush), .rdata(rdata), .done(done),
		.drequest(drequest), .dreqack(dreqack), .daddr(daddr), .dwrenable(dwrenable),
		.dwdata(dwdata), .drdata(drdata), .ddone(ddone)
	);

	dcache_mem_model #(.seed_init(32'h53fe_5be3)) mem_i (
		.clk(clk), .rst(rst), .drequest(drequest), .dreqack(dreqack), .daddr(daddr),
		.dwrenable(dwrenable), .dwdata(dwdata), .drdata(drdata), .ddone(ddone)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Each transfer is logged once in its acknowledge cycle
	always @(negedge clk) begin
		if (!rst && drequest && dreqack) begin
			mon_req.line_addr = daddr[31:6];
			mon_req.write = dwrenable;
			mon_req.data = dwdata;
			seen.push_back(mon_req);
		end
	end

	////////////////////////////////////////////////////////////
	// Golden memory and compare tasks
	////////////////////////////////////////////////////////////

	function automatic logic [63:0] golden_word(input logic [31:0] a);
		if (gold.exists(a[31:3]))
			return gold[a[31:3]];
		return {~a, a}; // Same pattern the line memory starts with
	endfunction

	function automatic dcache_pkg::dc_line_t golden_line(input logic [25:0] la);
		dcache_pkg::dc_line_t l;
		for (int w = 0; w < 8; w++)
			l.words[w] = golden_word({la, w[2:0], 3'b000});
		return l;
	endfunction

	task automatic check_word(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_line(input string name, input dcache_pkg::dc_line_t exp,
			input dcache_pkg::dc_line_t act);
		checks++;
		if (act.flat !== exp.flat) begin
			errors++;
			$display("Error %s: expected %h, actual %h", name, exp.flat, act.flat);
		end
	endtask

	task automatic check_xfer(input string name, input dcache_pkg::mem_req_t exp,
			input dcache_pkg::mem_req_t act);
		checks++;
		if (act.line_addr !== exp.line_addr || act.write !== exp.write) begin
			errors++;
			$display("Error %s: expected line %h write %b, actual line %h write %b",
				name, exp.line_addr, exp.write, act.line_addr, act.write);
		end
		if (exp.write && act.write)
			check_line({name, " data"}, exp.data, act.data);
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		checks++;
		if (act != exp) begin
			errors++;
			$display("Error %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	////////////////////////////////////////////////////////////
	// One random request with its prediction
	////////////////////////////////////////////////////////////

	task automatic run_op(input int n);
		logic [tag_w-1:0] t;
		logic [index_w-1:0] s;
		logic [31:0] a;
		logic [63:0] wd;
		logic [63:0] exp_rd;
		logic is_write;
		logic is_flush;
		logic saw_req;
		logic prev_ddone;
		int kind;
		int h;
		int v;
		int exp_lat;
		int cyc;
		dcache_pkg::mem_req_t xfer;
		dcache_pkg::mem_req_t exp_x [$];
		string name;

		t = tag_w'({$random(seed)} % 5) * 24'h01_0203; // Five tags fight over two sets
		s = index_w'({$random(seed)} % 2);
		a = {t, s, 3'({$random(seed)} % 8), 3'b000};
		wd = {$random(seed), $random(seed)};
		kind = {$random(seed)} % 10;
		is_write = kind >= 4 && kind < 8;
		is_flush = kind >= 8;
		name = $sformatf("op %0d addr %h", n, a);
		exp_rd = golden_word(a);
		exp_lat = -1;
		h = -1;
		for (int w = 0; w < 2; w++)
			if (sh_valid[w][s] && sh_tag[w][s] == t)
				h = w;

		if (is_flush) begin
			if (h >= 0) begin
				xfer.line_addr = {t, s};
				xfer.write = 1'b1;
				xfer.data = golden_line({t, s});
				exp_x.push_back(xfer);
				sh_valid[h][s] = 1'b0;
				sh_dirty[h][s] = 1'b0;
				sh_recent[h][s] = 1'b0;
			end else begin
				exp_lat = 2;
			end
		end else begin
			if (h >= 0) begin
				exp_lat = 2;
			end else begin
				v = !sh_valid[0][s] ? 0 : !sh_valid[1][s] ? 1 : !sh_recent[1][s] ? 1 : 0;
				if (sh_valid[v][s] && sh_dirty[v][s]) begin
					xfer.line_addr = {sh_tag[v][s], s};
					xfer.write = 1'b1;
					xfer.data = golden_line({sh_tag[v][s], s});
					exp_x.push_back(xfer);
				end
				xfer.line_addr = {t, s};
				xfer.write = 1'b0;
				xfer.data = '0;
				exp_x.push_back(xfer);
				sh_tag[v][s] = t;
				sh_valid[v][s] = 1'b1;
				sh_dirty[v][s] = 1'b0;
				h = v;
			end
			sh_recent[h][s] = 1'b1;
			if (sh_valid[1-h][s])
				sh_recent[1-h][s] = 1'b0;
			if (is_write) begin
				sh_dirty[h][s] = 1'b1;
				gold[a[31:3]] = wd;
			end
		end

		@(posedge clk);
		enable <= 1'b1;
		addr <= a;
		wdata <= wd;
		wen <= is_write;
		clflush <= is_flush;
		@(posedge clk);
		enable <= 1'b0; // Sampled at this edge
		saw_req = 1'b0;
		prev_ddone = 1'b0;
		for (cyc = 0; cyc < done_limit; cyc++) begin
			@(negedge clk);
			saw_req = saw_req | drequest;
			if (done)
				break;
			prev_ddone = ddone;
		end

		if (cyc == done_limit) begin
			timeouts++;
			$display("Timeout: op %0d got no done within %0d cycles", n, done_limit);
		end else begin
			if (exp_lat >= 0) begin
				check_count({name, " latency"}, exp_lat, cyc);
				check_count({name, " drequest"}, 0, int'(saw_req));
			end else begin
				check_count({name, " done after ddone"}, 1, int'(prev_ddone));
			end
			if (!is_write && !is_flush)
				check_word({name, " rdata"}, exp_rd, rdata);
			check_count({name, " transfers"}, exp_x.size(), seen.size());
			for (int i = 0; i < exp_x.size() && i < seen.size(); i++)
				check_xfer($sformatf("%s transfer %0d", name, i), exp_x[i], seen[i]);
		end
		seen.delete();
	endtask

	initial begin
		rst = 1'b1;
		enable = 1'b0;
		addr = '0;
		wdata = '0;
		wen = 1'b0;
		clflush = 1'b0;
		for (int w = 0; w < 2; w++) begin
			for (int s = 0; s < 4; s++) begin
				sh_tag[w][s] = '0;
				sh_valid[w][s] = 1'b0;
				sh_dirty[w][s] = 1'b0;
				sh_recent[w][s] = 1'b0;
			end
		end
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		repeat (4) begin
			@(negedge clk);
			if (done || drequest) begin
				errors++;
				$display("done or drequest went high after reset before any request");
			end
		end

		for (int n = 0; n < num_ops && timeouts == 0; n++)
			run_op(n);

		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule
